/* mempool_pkg.sv */
/*
 * Shared address map, sizes, register offsets and types of the system shell.
 * Modules take what they need by a wildcard import in their header.
 */
package mempool_pkg;

  localparam int unsigned DataWidth = 32;

  typedef logic [31:0]          addr_t;
  typedef logic [DataWidth-1:0] data_t;

  localparam int unsigned NumCores = 4;

  // L2 geometry, word interleaved over the banks
  localparam int unsigned NumL2Banks     = 4;
  localparam int unsigned L2BankNumWords = 256;
  localparam int unsigned L2Words        = NumL2Banks * L2BankNumWords;

  typedef logic [$clog2(L2Words)-1:0]        l2_word_t;
  typedef logic [$clog2(NumL2Banks)-1:0]     l2_bank_sel_t;
  typedef logic [$clog2(L2BankNumWords)-1:0] l2_bank_addr_t;

  // Address map
  localparam addr_t L2BaseAddr      = 32'h8000_0000;
  localparam addr_t L2EndAddr       = L2BaseAddr + 32'h0000_1000;
  localparam addr_t BootromBaseAddr = 32'hA000_0000;
  localparam int unsigned BootromWords = 64;
  localparam data_t BootromSeed     = 32'hB007_0000;
  localparam addr_t CtrlBaseAddr    = 32'h4000_0000;
  localparam addr_t CtrlEndAddr     = 32'h4000_0100;
  localparam data_t ErrorData       = 32'hBADC_AB1E;

  typedef enum logic [1:0] {
    TgtL2,
    TgtBootrom,
    TgtCtrl,
    TgtNone
  } target_e;

  // Control register byte offsets
  localparam logic [7:0] RegEoc      = 8'h00;
  localparam logic [7:0] RegWakeUp   = 8'h04;
  localparam logic [7:0] RegDmaSrc   = 8'h08;
  localparam logic [7:0] RegDmaDst   = 8'h0C;
  localparam logic [7:0] RegDmaLen   = 8'h10;
  localparam logic [7:0] RegDmaStart = 8'h14;

  // One bit wider than the word index so a full L2 copy fits
  typedef logic [$clog2(L2Words):0] dma_len_t;

endpackage : mempool_pkg

/* addr_decoder.sv */
/*
 * Host address decoder. Classifies each request by the address map, strobes
 * one target and merges the one-cycle read responses back to the host.
 */
`timescale 1ns/1ns

module addr_decoder
  import mempool_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       req_i,
  input  logic       we_i,
  input  addr_t      addr_i,
  input  data_t      wdata_i,
  output logic       l2_req_o,
  output logic       rom_req_o,
  output logic       ctrl_req_o,
  output logic       we_o,
  output data_t      wdata_o,
  output l2_word_t   word_o,
  output logic [7:0] offset_o,
  input  logic       l2_rvalid_i,
  input  data_t      l2_rdata_i,
  input  logic       rom_rvalid_i,
  input  data_t      rom_rdata_i,
  input  logic       ctrl_rvalid_i,
  input  data_t      ctrl_rdata_i,
  output logic       rvalid_o,
  output data_t      rdata_o
);

  target_e tgt;
  logic    err_rvalid_q;

  // Boot ROM window spans a full word index; rows past the image read zero
  always_comb begin
    if (addr_i >= L2BaseAddr && addr_i < L2EndAddr) begin
      tgt = TgtL2;
    end else if (addr_i >= BootromBaseAddr && addr_i < BootromBaseAddr + 4 * L2Words) begin
      tgt = TgtBootrom;
    end else if (addr_i >= CtrlBaseAddr && addr_i < CtrlEndAddr) begin
      tgt = TgtCtrl;
    end else begin
      tgt = TgtNone;
    end
  end

  // Writes to the ROM never reach it
  assign l2_req_o   = req_i && (tgt == TgtL2);
  assign rom_req_o  = req_i && !we_i && (tgt == TgtBootrom);
  assign ctrl_req_o = req_i && (tgt == TgtCtrl);
  assign we_o       = we_i;
  assign wdata_o    = wdata_i;
  assign word_o     = addr_i[$bits(l2_word_t)+1:2];
  assign offset_o   = addr_i[7:0];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      err_rvalid_q <= 1'b0;
    end else begin
      err_rvalid_q <= req_i && !we_i && (tgt == TgtNone);
    end
  end

  // Only one response can be valid in a given cycle
  assign rvalid_o = l2_rvalid_i | rom_rvalid_i | ctrl_rvalid_i | err_rvalid_q;

  always_comb begin
    if (l2_rvalid_i) begin
      rdata_o = l2_rdata_i;
    end else if (rom_rvalid_i) begin
      rdata_o = rom_rdata_i;
    end else if (ctrl_rvalid_i) begin
      rdata_o = ctrl_rdata_i;
    end else begin
      rdata_o = ErrorData;
    end
  end

endmodule : addr_decoder

/* l2_mem.sv */
/*
 * Word-interleaved L2 SRAM shared by the host and the DMA engine.
 * The host always wins; the DMA waits for its grant.
 */
`timescale 1ns/1ns

module l2_mem
  import mempool_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     host_req_i,
  input  logic     host_we_i,
  input  l2_word_t host_word_i,
  input  data_t    host_wdata_i,
  output logic     host_rvalid_o,
  output data_t    host_rdata_o,
  input  logic     dma_req_i,
  input  logic     dma_we_i,
  input  l2_word_t dma_word_i,
  input  data_t    dma_wdata_i,
  output logic     dma_gnt_o,
  output logic     dma_rvalid_o,
  output data_t    dma_rdata_o
);

  logic          acc_req, acc_we;
  l2_word_t      acc_word;
  data_t         acc_wdata;
  l2_bank_sel_t  acc_bank, rsel_q;
  l2_bank_addr_t acc_row;
  data_t         bank_rdata [NumL2Banks];

  // Host first, DMA only in otherwise idle cycles
  assign dma_gnt_o = dma_req_i && !host_req_i;
  assign acc_req   = host_req_i || dma_req_i;
  assign acc_we    = host_req_i ? host_we_i    : dma_we_i;
  assign acc_word  = host_req_i ? host_word_i  : dma_word_i;
  assign acc_wdata = host_req_i ? host_wdata_i : dma_wdata_i;

  // Low index bits pick the bank, the rest is the row
  assign acc_bank = acc_word[$bits(l2_bank_sel_t)-1:0];
  assign acc_row  = acc_word[$bits(l2_word_t)-1:$bits(l2_bank_sel_t)];

  for (genvar b = 0; b < NumL2Banks; b++) begin : gen_bank
    data_t mem [L2BankNumWords];
    logic  bank_req;

    assign bank_req = acc_req && (acc_bank == l2_bank_sel_t'(b));

    always_ff @(posedge clk_i) begin
      if (bank_req) begin
        if (acc_we) begin
          mem[acc_row] <= acc_wdata;
        end else begin
          bank_rdata[b] <= mem[acc_row];
        end
      end
    end
  end

  // Remember who was served and from which bank
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      host_rvalid_o <= 1'b0;
      dma_rvalid_o  <= 1'b0;
      rsel_q        <= '0;
    end else begin
      host_rvalid_o <= host_req_i && !host_we_i;
      dma_rvalid_o  <= dma_gnt_o && !dma_we_i;
      rsel_q        <= acc_bank;
    end
  end

  assign host_rdata_o = bank_rdata[rsel_q];
  assign dma_rdata_o  = bank_rdata[rsel_q];

endmodule : l2_mem

/* bootrom.sv */
/*
 * Boot ROM with generated contents: word i holds the seed plus i.
 * Indices past the image read as zero.
 */
`timescale 1ns/1ns

module bootrom
  import mempool_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     req_i,
  input  l2_word_t word_i,
  output logic     rvalid_o,
  output data_t    rdata_o
);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= req_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= (word_i < BootromWords) ? BootromSeed + data_t'(word_i) : '0;
    end
  end

endmodule : bootrom

/* ctrl_regs.sv */
/*
 * Control and status registers: end of computation, core wake-up and
 * the DMA configuration with its start trigger.
 */
`timescale 1ns/1ns

module ctrl_regs
  import mempool_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                req_i,
  input  logic                we_i,
  input  logic [7:0]          offset_i,
  input  data_t               wdata_i,
  input  logic                dma_busy_i,
  output logic                rvalid_o,
  output data_t               rdata_o,
  output logic [NumCores-1:0] wake_up_o,
  output logic                eoc_valid_o,
  output l2_word_t            dma_src_o,
  output l2_word_t            dma_dst_o,
  output dma_len_t            dma_len_o,
  output logic                dma_start_o
);

  data_t eoc_q;
  logic  wr;

  assign wr          = req_i && we_i;
  assign eoc_valid_o = eoc_q[0];

  // Launch only an idle engine with a non-empty copy
  assign dma_start_o = wr && (offset_i == RegDmaStart) && !dma_busy_i && (dma_len_o != '0);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      eoc_q     <= '0;
      wake_up_o <= '0;
      dma_src_o <= '0;
      dma_dst_o <= '0;
      dma_len_o <= '0;
      rvalid_o  <= 1'b0;
    end else begin
      rvalid_o  <= req_i && !we_i;
      // Wake-up is a single-cycle pulse
      wake_up_o <= '0;
      if (wr) begin
        case (offset_i)
          RegEoc:    eoc_q     <= wdata_i;
          RegWakeUp: wake_up_o <= wdata_i[NumCores-1:0];
          RegDmaSrc: dma_src_o <= wdata_i[$bits(l2_word_t)-1:0];
          RegDmaDst: dma_dst_o <= wdata_i[$bits(l2_word_t)-1:0];
          RegDmaLen: dma_len_o <= wdata_i[$bits(dma_len_t)-1:0];
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      case (offset_i)
        RegEoc:      rdata_o <= eoc_q;
        RegDmaSrc:   rdata_o <= data_t'(dma_src_o);
        RegDmaDst:   rdata_o <= data_t'(dma_dst_o);
        RegDmaLen:   rdata_o <= data_t'(dma_len_o);
        RegDmaStart: rdata_o <= data_t'(dma_busy_i);
        // Wake-up and unknown offsets
        default:     rdata_o <= '0;
      endcase
    end
  end

endmodule : ctrl_regs

/* dma_counter.sv */
/*
 * Remaining-word and offset counter that steers the DMA engine.
 * Loaded at start, stepped once per written word.
 */
`timescale 1ns/1ns

module dma_counter
  import mempool_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     load_i,
  input  dma_len_t len_i,
  input  logic     step_i,
  output l2_word_t offset_o,
  output logic     last_o
);

  dma_len_t remain_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      remain_q <= '0;
      offset_o <= '0;
    end else if (load_i) begin
      remain_q <= len_i;
      offset_o <= '0;
    end else if (step_i) begin
      remain_q <= remain_q - 1'b1;
      offset_o <= offset_o + 1'b1;
    end
  end

  // One word left means the current one is the final one
  assign last_o = (remain_q == dma_len_t'(1));

endmodule : dma_counter

/* dma_fsm.sv */
/*
 * DMA state machine. Copies one word per pass inside L2: read the source,
 * wait for the data, write the destination, then step the counter.
 */
`timescale 1ns/1ns

module dma_fsm
  import mempool_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     start_i,
  input  l2_word_t src_i,
  input  l2_word_t dst_i,
  input  l2_word_t offset_i,
  input  logic     last_i,
  input  logic     gnt_i,
  input  logic     rvalid_i,
  input  data_t    rdata_i,
  output logic     load_o,
  output logic     step_o,
  output logic     req_o,
  output logic     we_o,
  output l2_word_t word_o,
  output data_t    wdata_o,
  output logic     busy_o
);

  typedef enum logic [1:0] {
    Idle,
    Read,
    Wait,
    Write
  } state_e;

  state_e state_q, state_d;
  data_t  data_q;

  assign busy_o  = (state_q != Idle);
  assign load_o  = (state_q == Idle) && start_i;
  assign req_o   = (state_q == Read) || (state_q == Write);
  assign we_o    = (state_q == Write);
  assign word_o  = (state_q == Write) ? dst_i + offset_i : src_i + offset_i;
  assign wdata_o = data_q;
  assign step_o  = (state_q == Write) && gnt_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      Idle:  if (start_i) state_d = Read;
      Read:  if (gnt_i) state_d = Wait;
      Wait:  if (rvalid_i) state_d = Write;
      Write: if (gnt_i) state_d = last_i ? Idle : Read;
      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Hold the source word until the write is granted
  always_ff @(posedge clk_i) begin
    if (state_q == Wait && rvalid_i) begin
      data_q <= rdata_i;
    end
  end

endmodule : dma_fsm

/* mempool_system.sv */
/*
 * System shell top level. A single host port reaches L2, boot ROM and the
 * control registers; a small DMA engine copies blocks inside L2.
 */
`timescale 1ns/1ns

module mempool_system
  import mempool_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                req_i,
  input  logic                we_i,
  input  addr_t               addr_i,
  input  data_t               wdata_i,
  output logic                rvalid_o,
  output data_t               rdata_o,
  output logic [NumCores-1:0] wake_up_o,
  output logic                eoc_valid_o,
  output logic                busy_o
);

  // Decoder to targets
  logic       l2_req, rom_req, ctrl_req, tgt_we;
  data_t      tgt_wdata;
  l2_word_t   tgt_word;
  logic [7:0] tgt_offset;

  // Target responses
  logic  l2_rvalid, rom_rvalid, ctrl_rvalid;
  data_t l2_rdata, rom_rdata, ctrl_rdata;

  // DMA side of L2
  logic     dma_req, dma_we, dma_gnt, dma_rvalid;
  l2_word_t dma_word;
  data_t    dma_wdata, dma_rdata;

  // DMA configuration and counter
  l2_word_t dma_src, dma_dst, dma_offset;
  dma_len_t dma_len;
  logic     dma_start, dma_busy, dma_load, dma_step, dma_last;

  assign busy_o = dma_busy;

  addr_decoder i_addr_decoder (
    .clk_i        (clk_i      ),
    .rst_i        (rst_i      ),
    .req_i        (req_i      ),
    .we_i         (we_i       ),
    .addr_i       (addr_i     ),
    .wdata_i      (wdata_i    ),
    .l2_req_o     (l2_req     ),
    .rom_req_o    (rom_req    ),
    .ctrl_req_o   (ctrl_req   ),
    .we_o         (tgt_we     ),
    .wdata_o      (tgt_wdata  ),
    .word_o       (tgt_word   ),
    .offset_o     (tgt_offset ),
    .l2_rvalid_i  (l2_rvalid  ),
    .l2_rdata_i   (l2_rdata   ),
    .rom_rvalid_i (rom_rvalid ),
    .rom_rdata_i  (rom_rdata  ),
    .ctrl_rvalid_i(ctrl_rvalid),
    .ctrl_rdata_i (ctrl_rdata ),
    .rvalid_o     (rvalid_o   ),
    .rdata_o      (rdata_o    )
  );

  l2_mem i_l2_mem (
    .clk_i        (clk_i     ),
    .rst_i        (rst_i     ),
    .host_req_i   (l2_req    ),
    .host_we_i    (tgt_we    ),
    .host_word_i  (tgt_word  ),
    .host_wdata_i (tgt_wdata ),
    .host_rvalid_o(l2_rvalid ),
    .host_rdata_o (l2_rdata  ),
    .dma_req_i    (dma_req   ),
    .dma_we_i     (dma_we    ),
    .dma_word_i   (dma_word  ),
    .dma_wdata_i  (dma_wdata ),
    .dma_gnt_o    (dma_gnt   ),
    .dma_rvalid_o (dma_rvalid),
    .dma_rdata_o  (dma_rdata )
  );

  bootrom i_bootrom (
    .clk_i   (clk_i     ),
    .rst_i   (rst_i     ),
    .req_i   (rom_req   ),
    .word_i  (tgt_word  ),
    .rvalid_o(rom_rvalid),
    .rdata_o (rom_rdata )
  );

  ctrl_regs i_ctrl_regs (
    .clk_i      (clk_i      ),
    .rst_i      (rst_i      ),
    .req_i      (ctrl_req   ),
    .we_i       (tgt_we     ),
    .offset_i   (tgt_offset ),
    .wdata_i    (tgt_wdata  ),
    .dma_busy_i (dma_busy   ),
    .rvalid_o   (ctrl_rvalid),
    .rdata_o    (ctrl_rdata ),
    .wake_up_o  (wake_up_o  ),
    .eoc_valid_o(eoc_valid_o),
    .dma_src_o  (dma_src    ),
    .dma_dst_o  (dma_dst    ),
    .dma_len_o  (dma_len    ),
    .dma_start_o(dma_start  )
  );

  dma_fsm i_dma_fsm (
    .clk_i   (clk_i     ),
    .rst_i   (rst_i     ),
    .start_i (dma_start ),
    .src_i   (dma_src   ),
    .dst_i   (dma_dst   ),
    .offset_i(dma_offset),
    .last_i  (dma_last  ),
    .gnt_i   (dma_gnt   ),
    .rvalid_i(dma_rvalid),
    .rdata_i (dma_rdata ),
    .load_o  (dma_load  ),
    .step_o  (dma_step  ),
    .req_o   (dma_req   ),
    .we_o    (dma_we    ),
    .word_o  (dma_word  ),
    .wdata_o (dma_wdata ),
    .busy_o  (dma_busy  )
  );

  dma_counter i_dma_counter (
    .clk_i   (clk_i     ),
    .rst_i   (rst_i     ),
    .load_i  (dma_load  ),
    .len_i   (dma_len   ),
    .step_i  (dma_step  ),
    .offset_o(dma_offset),
    .last_o  (dma_last  )
  );

endmodule : mempool_system

/* mempool_system_tb.sv */
/*
 * Self-checking testbench for the system shell. Drives the host port, keeps a
 * reference model of L2, boot ROM and control registers, and checks every read.
 */
`timescale 1ns/1ns

module mempool_system_tb
  import mempool_pkg::*;
();

  localparam int unsigned L2TestWords = 128;
  localparam int unsigned DmaSrcWord  = 'h100;
  localparam int unsigned DmaDstWord  = 'h200;
  localparam int unsigned DmaLen      = 16;
  localparam int unsigned TrafficWord = 'h300;
  localparam int unsigned TrafficOps  = 24;
  // Sum of the test phases with a margin for DMA stalls
  localparam int unsigned TimeoutCycles =
      2 * (3 * L2TestWords + 9 * DmaLen + 6 * TrafficOps + 100);

  logic                clk_i = 1'b0;
  logic                rst_i, req_i, we_i;
  addr_t               addr_i;
  data_t               wdata_i;
  logic                rvalid_o;
  data_t               rdata_o;
  logic [NumCores-1:0] wake_up_o;
  logic                eoc_valid_o, busy_o;

  // Reference model state
  data_t    shadow_l2 [L2Words];
  data_t    model_eoc;
  l2_word_t model_src, model_dst;
  dma_len_t model_len;
  logic     model_busy;

  // Expected responses for the next cycle
  logic                pend_valid;
  data_t               pend_data;
  logic [NumCores-1:0] pend_wake;

  logic [31:0] lfsr_q;
  int          value_errs, resp_errs, cycle_cnt;

  mempool_system DUT (
    .clk_i      (clk_i      ),
    .rst_i      (rst_i      ),
    .req_i      (req_i      ),
    .we_i       (we_i       ),
    .addr_i     (addr_i     ),
    .wdata_i    (wdata_i    ),
    .rvalid_o   (rvalid_o   ),
    .rdata_o    (rdata_o    ),
    .wake_up_o  (wake_up_o  ),
    .eoc_valid_o(eoc_valid_o),
    .busy_o     (busy_o     )
  );

  always #50 clk_i = ~clk_i;

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  function automatic addr_t l2_addr(input int unsigned word);
    return L2BaseAddr + addr_t'(word) * 4;
  endfunction

  function automatic addr_t ctrl_addr(input logic [7:0] off);
    return CtrlBaseAddr + addr_t'(off);
  endfunction

  // Expected read data for any host address
  function automatic data_t ref_read(input addr_t addr);
    int unsigned idx;
    if (addr >= L2BaseAddr && addr < L2EndAddr) begin
      return shadow_l2[(addr - L2BaseAddr) >> 2];
    end
    if (addr >= BootromBaseAddr && addr < BootromBaseAddr + 32'h1000) begin
      idx = (addr - BootromBaseAddr) >> 2;
      return (idx < BootromWords) ? BootromSeed + idx : '0;
    end
    if (addr >= CtrlBaseAddr && addr < CtrlEndAddr) begin
      case (addr[7:0])
        RegEoc:      return model_eoc;
        RegDmaSrc:   return data_t'(model_src);
        RegDmaDst:   return data_t'(model_dst);
        RegDmaLen:   return data_t'(model_len);
        RegDmaStart: return data_t'(model_busy);
        default:     return '0;
      endcase
    end
    return ErrorData;
  endfunction

  // ROM and unmapped writes leave the model untouched
  task automatic model_write(input addr_t addr, input data_t data);
    if (addr >= L2BaseAddr && addr < L2EndAddr) begin
      shadow_l2[(addr - L2BaseAddr) >> 2] = data;
    end else if (addr >= CtrlBaseAddr && addr < CtrlEndAddr) begin
      case (addr[7:0])
        RegEoc:      model_eoc = data;
        RegDmaSrc:   model_src = l2_word_t'(data);
        RegDmaDst:   model_dst = l2_word_t'(data);
        RegDmaLen:   model_len = dma_len_t'(data);
        RegDmaStart: if (!model_busy && model_len != '0) model_busy = 1'b1;
        default: ;
      endcase
    end
  endtask

  task automatic host_write(input addr_t addr, input data_t data);
    @(posedge clk_i);
    req_i   <= 1'b1;
    we_i    <= 1'b1;
    addr_i  <= addr;
    wdata_i <= data;
  endtask

  task automatic host_read(input addr_t addr);
    @(posedge clk_i);
    req_i  <= 1'b1;
    we_i   <= 1'b0;
    addr_i <= addr;
  endtask

  task automatic bus_idle(input int unsigned n);
    repeat (n) begin
      @(posedge clk_i);
      req_i <= 1'b0;
    end
  endtask

  // Compare at the falling edge, then predict from the request on the bus
  always @(negedge clk_i) begin
    assert (rvalid_o === pend_valid) else begin
      if (pend_valid) begin
        $display("Read response missing at %0t ns", $time);
      end else begin
        $display("Unexpected read response at %0t ns", $time);
      end
      resp_errs++;
    end
    if (pend_valid && rvalid_o === 1'b1) begin
      assert (rdata_o === pend_data) else begin
        $display("Error at %0t ns: read data %h, expected %h", $time, rdata_o, pend_data);
        value_errs++;
      end
    end
    assert (wake_up_o === pend_wake) else begin
      $display("Error at %0t ns: wake_up_o %b, expected %b", $time, wake_up_o, pend_wake);
      value_errs++;
    end
    assert (eoc_valid_o === model_eoc[0]) else begin
      $display("Error at %0t ns: eoc_valid_o %b, expected %b", $time, eoc_valid_o,
               model_eoc[0]);
      value_errs++;
    end
    pend_valid = req_i && !we_i;
    pend_wake  = '0;
    if (req_i && !we_i) begin
      pend_data = ref_read(addr_i);
    end
    if (req_i && we_i) begin
      if (addr_i == ctrl_addr(RegWakeUp)) begin
        pend_wake = wdata_i[NumCores-1:0];
      end
      model_write(addr_i, wdata_i);
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TimeoutCycles) begin
      $display("Timeout after %0d cycles, the tests did not finish", cycle_cnt);
      $display("Result: FAILED");
      $finish;
    end
  end

  initial begin
    int unsigned word;
    lfsr_q     = 32'h6526;
    value_errs = 0;
    resp_errs  = 0;
    cycle_cnt  = 0;
    rst_i      = 1'b1;
    req_i      = 1'b0;
    we_i       = 1'b0;
    addr_i     = '0;
    wdata_i    = '0;
    model_eoc  = '0;
    model_src  = '0;
    model_dst  = '0;
    model_len  = '0;
    model_busy = 1'b0;
    pend_valid = 1'b0;
    pend_data  = '0;
    pend_wake  = '0;
    repeat (4) @(posedge clk_i);
    rst_i <= 1'b0;
    @(negedge clk_i);
    assert (busy_o === 1'b0) else begin
      $display("Error at %0t ns: busy_o high after reset", $time);
      value_errs++;
    end

    // L2 over all banks, some words written twice
    for (int w = 0; w < L2TestWords; w++) begin
      host_write(l2_addr(w), rand_bits(32));
    end
    for (int k = 0; k < 32; k++) begin
      word = rand_bits(7);
      host_write(l2_addr(word), rand_bits(32));
    end
    for (int w = L2TestWords - 1; w >= 0; w--) begin
      host_read(l2_addr(w));
    end
    bus_idle(2);

    // Boot ROM, including a dropped write and a row past the image
    for (int i = 0; i < BootromWords; i += 5) begin
      host_read(BootromBaseAddr + 4 * i);
    end
    host_read(BootromBaseAddr + 4 * 100);
    host_write(BootromBaseAddr + 4 * 7, 32'hDEAD_BEEF);
    host_read(BootromBaseAddr + 4 * 7);
    bus_idle(2);

    // EOC and wake-up
    host_write(ctrl_addr(RegEoc), 32'h0000_0A5B);
    bus_idle(2);
    host_read(ctrl_addr(RegEoc));
    host_write(ctrl_addr(RegEoc), 32'h0000_1234);
    host_read(ctrl_addr(RegEoc));
    host_write(ctrl_addr(RegWakeUp), 32'hFFFF_FFF5);
    bus_idle(3);
    host_write(ctrl_addr(RegWakeUp), 32'h0000_000A);
    host_read(ctrl_addr(RegWakeUp));
    bus_idle(3);

    // Unmapped reads and a dropped write
    host_read(32'h0000_0000);
    host_read(L2EndAddr);
    host_read(CtrlEndAddr);
    host_write(32'hC000_0010, 32'h1234_5678);
    host_read(32'hC000_0010);
    bus_idle(2);

    // DMA copy with host traffic in a third region
    for (int i = 0; i < DmaLen; i++) begin
      host_write(l2_addr(DmaSrcWord + i), rand_bits(32));
    end
    host_write(ctrl_addr(RegDmaSrc), DmaSrcWord);
    host_write(ctrl_addr(RegDmaDst), DmaDstWord);
    host_write(ctrl_addr(RegDmaLen), DmaLen);
    host_read(ctrl_addr(RegDmaLen));
    host_write(ctrl_addr(RegDmaStart), 32'h1);
    @(negedge clk_i);
    assert (busy_o === 1'b0) else begin
      $display("Error at %0t ns: busy_o high before the start write", $time);
      value_errs++;
    end
    bus_idle(1);
    @(negedge clk_i);
    assert (busy_o === 1'b1) else begin
      $display("Error at %0t ns: busy_o low the cycle after start", $time);
      value_errs++;
    end
    host_read(ctrl_addr(RegDmaStart));
    for (int i = 0; i < TrafficOps; i++) begin
      host_write(l2_addr(TrafficWord + i), rand_bits(32));
      bus_idle(1);
      word = TrafficWord + rand_bits(5) % (i + 1);
      host_read(l2_addr(word));
    end
    bus_idle(1);
    @(negedge clk_i);
    while (busy_o) @(negedge clk_i);
    model_busy = 1'b0;
    for (int i = 0; i < DmaLen; i++) begin
      shadow_l2[DmaDstWord + i] = shadow_l2[DmaSrcWord + i];
    end
    host_read(ctrl_addr(RegDmaStart));
    for (int i = 0; i < DmaLen; i++) begin
      host_read(l2_addr(DmaDstWord + i));
    end
    for (int i = 0; i < DmaLen; i++) begin
      host_read(l2_addr(DmaSrcWord + i));
    end
    for (int i = 0; i < TrafficOps; i++) begin
      host_read(l2_addr(TrafficWord + i));
    end
    bus_idle(3);

    $display("Checks done: %0d wrong values, %0d response errors", value_errs, resp_errs);
    if (value_errs == 0 && resp_errs == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule : mempool_system_tb

/* mempool_system.f */
mempool_pkg.sv
addr_decoder.sv
l2_mem.sv
bootrom.sv
ctrl_regs.sv
dma_counter.sv
dma_fsm.sv
mempool_system.sv
mempool_system_tb.sv
